// File: hw/valu_cfg_pkg.sv
`default_nettype none

package valu_cfg_pkg;

    localparam int data_w   = 64;
    localparam int addr_w   = 32;
    localparam int vl_w     = 8;
    localparam int be_w     = data_w / 8;
    localparam int off_w    = 8;
    localparam int pipe_lat = 3;   // decode, unit, response

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [vl_w-1:0]   vl_t;
    typedef logic [be_w-1:0]   be_t;
    typedef logic [off_w-1:0]  off_t;
    typedef logic [1:0]        sew_t;  // 0:8b 1:16b 2:32b 3:64b

endpackage

`default_nettype wire

// File: hw/valu_op_pkg.sv
`default_nettype none

package valu_op_pkg;

    typedef logic [5:0] func_t;
    typedef logic [2:0] mnr_t;

    localparam mnr_t mnr_mvv = 3'd2;   // reductions live here

    // elementwise codes, any op-minor except mvv
    localparam func_t func_add  = 6'b000000;
    localparam func_t func_sub  = 6'b000010;
    localparam func_t func_rsub = 6'b000011;
    localparam func_t func_minu = 6'b000100;
    localparam func_t func_min  = 6'b000101;
    localparam func_t func_maxu = 6'b000110;
    localparam func_t func_max  = 6'b000111;
    localparam func_t func_and  = 6'b001001;
    localparam func_t func_or   = 6'b001010;
    localparam func_t func_xor  = 6'b001011;
    localparam func_t func_move = 6'b010111;

    typedef enum logic [2:0] {
        arith_add, arith_sub, arith_rsub, arith_minu, arith_min, arith_maxu, arith_max
    } arith_op_t;

    typedef enum logic [1:0] {logic_and, logic_or, logic_xor, logic_move} logic_op_t;

    // values equal func_id[2:0] of the reduction codes
    typedef enum logic [2:0] {
        red_sum, red_and, red_or, red_xor, red_minu, red_min, red_maxu, red_max
    } red_op_t;

endpackage

`default_nettype wire

// File: hw/sideband_delay.sv
`timescale 1ns/1ps
`default_nettype none

module sideband_delay import valu_cfg_pkg::*; #(
    parameter type payload_t = logic,
    parameter int  depth     = pipe_lat
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire payload_t in_data,
    output payload_t      out_data
);

    payload_t stage [depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in_data;
            for (int i = 1; i < depth; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out_data = stage[depth-1];

endmodule

`default_nettype wire

// File: hw/valu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module valu_decode import valu_cfg_pkg::*, valu_op_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      req_valid,
    input  wire mnr_t      req_op_mnr,
    input  wire func_t     req_func_id,
    input  wire logic      req_mask,
    input  wire sew_t      req_sew,
    input  wire data_t     req_data0,
    input  wire data_t     req_data1,
    input  wire be_t       req_be,
    input  wire logic      req_start,
    input  wire logic      req_end,
    output logic           arith_valid,
    output arith_op_t      arith_op,
    output logic           logic_valid,
    output logic_op_t      logic_op,
    output logic           red_valid,
    output red_op_t        red_op,
    output sew_t           op_sew,
    output data_t          op_data0,
    output data_t          op_data1,
    output be_t            op_be,
    output logic           op_start,
    output logic           op_end
);

    logic      a_hit;
    logic      l_hit;
    logic      r_hit;
    arith_op_t a_op;
    logic_op_t l_op;

    always_comb begin
        a_hit = 1'b0;
        l_hit = 1'b0;
        r_hit = (req_op_mnr == mnr_mvv) && (req_func_id[5:3] == 3'b000);
        a_op  = arith_add;
        l_op  = logic_and;
        if (req_op_mnr != mnr_mvv) begin
            case (req_func_id)
                func_add:  begin a_hit = 1'b1; a_op = arith_add;  end
                func_sub:  begin a_hit = 1'b1; a_op = arith_sub;  end
                func_rsub: begin a_hit = 1'b1; a_op = arith_rsub; end
                func_minu: begin a_hit = 1'b1; a_op = arith_minu; end
                func_min:  begin a_hit = 1'b1; a_op = arith_min;  end
                func_maxu: begin a_hit = 1'b1; a_op = arith_maxu; end
                func_max:  begin a_hit = 1'b1; a_op = arith_max;  end
                func_and:  begin l_hit = 1'b1; l_op = logic_and;  end
                func_or:   begin l_hit = 1'b1; l_op = logic_or;   end
                func_xor:  begin l_hit = 1'b1; l_op = logic_xor;  end
                func_move: begin l_hit = req_mask; l_op = logic_move; end  // merge when unmasked
                default:   ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arith_valid <= 1'b0;
            logic_valid <= 1'b0;
            red_valid   <= 1'b0;
            op_start    <= 1'b0;
            op_end      <= 1'b0;
        end else begin
            arith_valid <= req_valid & a_hit;
            logic_valid <= req_valid & l_hit;
            red_valid   <= req_valid & r_hit;
            op_start    <= req_start;
            op_end      <= req_end;
        end
    end

    // payload, qualified by the unit valids
    always_ff @(posedge clk) begin
        arith_op <= a_op;
        logic_op <= l_op;
        red_op   <= red_op_t'(req_func_id[2:0]);
        op_sew   <= req_sew;
        op_data0 <= req_data0;
        op_data1 <= req_data1;
        op_be    <= req_be;
    end

endmodule

`default_nettype wire

// File: hw/valu_arith.sv
`timescale 1ns/1ps
`default_nettype none

module valu_arith import valu_cfg_pkg::*, valu_op_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      in_valid,
    input  wire arith_op_t in_op,
    input  wire sew_t      in_sew,
    input  wire data_t     in_data0,
    input  wire data_t     in_data1,
    output logic           out_valid,
    output data_t          out_data
);

    // one full-width result per element width
    wire [data_w-1:0] lane_res [4];

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int ew = 8 << s;
        for (genvar i = 0; i < data_w / ew; i++) begin : g_lane
            logic [ew-1:0] a;   // vs1 element
            logic [ew-1:0] b;   // vs2 element
            logic [ew-1:0] r;

            assign a = in_data0[i*ew +: ew];
            assign b = in_data1[i*ew +: ew];

            always_comb begin
                case (in_op)
                    arith_add:  r = b + a;
                    arith_sub:  r = b - a;
                    arith_rsub: r = a - b;
                    arith_minu: r = (b < a) ? b : a;
                    arith_min:  r = ($signed(b) < $signed(a)) ? b : a;
                    arith_maxu: r = (b > a) ? b : a;
                    arith_max:  r = ($signed(b) > $signed(a)) ? b : a;
                    default:    r = b + a;
                endcase
            end

            assign lane_res[s][i*ew +: ew] = r;  // carry stays in lane
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= in_valid;
            out_data  <= in_valid ? lane_res[in_sew] : '0;  // zero for the OR merge
        end
    end

endmodule

`default_nettype wire

// File: hw/valu_logic.sv
`timescale 1ns/1ps
`default_nettype none

module valu_logic import valu_cfg_pkg::*, valu_op_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      in_valid,
    input  wire logic_op_t in_op,
    input  wire data_t     in_data0,
    input  wire data_t     in_data1,
    output logic           out_valid,
    output data_t          out_data
);

    data_t res;

    always_comb begin
        case (in_op)
            logic_and: res = in_data0 & in_data1;
            logic_or:  res = in_data0 | in_data1;
            logic_xor: res = in_data0 ^ in_data1;
            default:   res = in_data0;   // vmv.v, scalar or vector source
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= in_valid;
            out_data  <= in_valid ? res : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/valu_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module valu_reduce import valu_cfg_pkg::*, valu_op_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    in_valid,
    input  wire red_op_t in_op,
    input  wire sew_t    in_sew,
    input  wire data_t   in_data0,
    input  wire data_t   in_data1,
    input  wire be_t     in_be,
    input  wire logic    in_start,
    input  wire logic    in_end,
    output logic         out_valid,
    output data_t        out_data
);

    data_t acc;     // running value, kept extended to 64 bits
    data_t fold;
    logic  sgn;

    function automatic data_t lane_mask(sew_t s);
        lane_mask = {data_w{1'b1}} >> (data_w - (8 << s));
    endfunction

    // lane 0 of v, sign or zero extended so one 64-bit compare serves every sew
    function automatic data_t ext(data_t v, sew_t s, logic sg);
        data_t m;
        m   = lane_mask(s);
        ext = (v & m) | ((sg && v[(8 << s) - 1]) ? ~m : '0);
    endfunction

    function automatic data_t combine(red_op_t op, data_t x, data_t y);
        case (op)
            red_sum:  combine = x + y;
            red_and:  combine = x & y;
            red_or:   combine = x | y;
            red_xor:  combine = x ^ y;
            red_minu: combine = (y < x) ? y : x;
            red_min:  combine = ($signed(y) < $signed(x)) ? y : x;
            red_maxu: combine = (y > x) ? y : x;
            default:  combine = ($signed(y) > $signed(x)) ? y : x;
        endcase
    endfunction

    always_comb begin
        sgn  = (in_op == red_min) || (in_op == red_max);
        fold = in_start ? ext(in_data0, in_sew, sgn) : acc;
        // skipping a masked element is the same as folding in the identity
        for (int i = 0; i < be_w; i++) begin
            if ((i < (be_w >> in_sew)) && in_be[i << in_sew]) begin
                fold = combine(in_op, fold, ext(in_data1 >> (i * (8 << in_sew)), in_sew, sgn));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            acc <= fold;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= in_valid & in_end;
            out_data  <= (in_valid & in_end) ? (fold & lane_mask(in_sew)) : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/valu_resp.sv
`timescale 1ns/1ps
`default_nettype none

module valu_resp import valu_cfg_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  arith_valid,
    input  wire data_t arith_data,
    input  wire logic  logic_valid,
    input  wire data_t logic_data,
    input  wire logic  red_valid,
    input  wire data_t red_data,
    output logic       resp_valid,
    output data_t      resp_data,
    output logic       resp_sca
);

    // at most one unit is active per cycle, idle units drive zero

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
            resp_sca   <= 1'b0;
        end else begin
            resp_valid <= arith_valid | logic_valid | red_valid;
            resp_data  <= arith_data | logic_data | red_data;
            resp_sca   <= red_valid;   // reduction result sits in element 0
        end
    end

endmodule

`default_nettype wire

// File: hw/valu_top.sv
`timescale 1ns/1ps
`default_nettype none

module valu_top import valu_cfg_pkg::*, valu_op_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  req_valid,
    input  wire mnr_t  req_op_mnr,
    input  wire func_t req_func_id,
    input  wire sew_t  req_sew,
    input  wire data_t req_data0,
    input  wire data_t req_data1,
    input  wire be_t   req_be,
    input  wire addr_t req_addr,
    input  wire vl_t   req_vl,
    input  wire logic  req_start,
    input  wire logic  req_end,
    input  wire logic  req_mask,
    input  wire off_t  req_off,
    output logic       resp_valid,
    output data_t      resp_data,
    output sew_t       resp_sew,
    output logic       resp_start,
    output logic       resp_end,
    output logic       resp_sca,
    output addr_t      resp_addr,
    output vl_t        resp_vl,
    output be_t        resp_be,
    output off_t       resp_off
);

    typedef struct packed {
        be_t  be;
        sew_t sew;
        logic is_start;
        logic is_end;
    } side_t;

    logic      arith_valid, logic_valid, red_valid;
    arith_op_t arith_op;
    logic_op_t logic_op;
    red_op_t   red_op;
    sew_t      op_sew;
    data_t     op_data0, op_data1;
    be_t       op_be;
    logic      op_start, op_end;
    logic      arith_out_valid, logic_out_valid, red_out_valid;
    data_t     arith_out_data, logic_out_data, red_out_data;
    side_t     side_in, side_out;

    valu_decode u_decode (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_op_mnr(req_op_mnr),
        .req_func_id(req_func_id), .req_mask(req_mask), .req_sew(req_sew),
        .req_data0(req_data0), .req_data1(req_data1), .req_be(req_be),
        .req_start(req_start), .req_end(req_end),
        .arith_valid(arith_valid), .arith_op(arith_op), .logic_valid(logic_valid),
        .logic_op(logic_op), .red_valid(red_valid), .red_op(red_op), .op_sew(op_sew),
        .op_data0(op_data0), .op_data1(op_data1), .op_be(op_be),
        .op_start(op_start), .op_end(op_end)
    );

    valu_arith u_arith (
        .clk(clk), .rst(rst), .in_valid(arith_valid), .in_op(arith_op), .in_sew(op_sew),
        .in_data0(op_data0), .in_data1(op_data1),
        .out_valid(arith_out_valid), .out_data(arith_out_data)
    );

    valu_logic u_logic (
        .clk(clk), .rst(rst), .in_valid(logic_valid), .in_op(logic_op),
        .in_data0(op_data0), .in_data1(op_data1),
        .out_valid(logic_out_valid), .out_data(logic_out_data)
    );

    valu_reduce u_reduce (
        .clk(clk), .rst(rst), .in_valid(red_valid), .in_op(red_op), .in_sew(op_sew),
        .in_data0(op_data0), .in_data1(op_data1), .in_be(op_be),
        .in_start(op_start), .in_end(op_end),
        .out_valid(red_out_valid), .out_data(red_out_data)
    );

    valu_resp u_resp (
        .clk(clk), .rst(rst),
        .arith_valid(arith_out_valid), .arith_data(arith_out_data),
        .logic_valid(logic_out_valid), .logic_data(logic_out_data),
        .red_valid(red_out_valid), .red_data(red_out_data),
        .resp_valid(resp_valid), .resp_data(resp_data), .resp_sca(resp_sca)
    );

    // start and end only count on a valid beat
    assign side_in = '{be: req_be, sew: req_sew,
                       is_start: req_start & req_valid, is_end: req_end & req_valid};

    sideband_delay #(.payload_t(addr_t)) u_dly_addr (
        .clk(clk), .rst(rst), .in_data(req_addr), .out_data(resp_addr)
    );

    sideband_delay #(.payload_t(vl_t)) u_dly_vl (
        .clk(clk), .rst(rst), .in_data(req_vl), .out_data(resp_vl)
    );

    sideband_delay #(.payload_t(off_t)) u_dly_off (
        .clk(clk), .rst(rst), .in_data(req_off), .out_data(resp_off)
    );

    sideband_delay #(.payload_t(side_t)) u_dly_side (
        .clk(clk), .rst(rst), .in_data(side_in), .out_data(side_out)
    );

    assign resp_be    = side_out.be;
    assign resp_sew   = side_out.sew;
    assign resp_start = side_out.is_start;
    assign resp_end   = side_out.is_end;

endmodule

`default_nettype wire

// File: tests/valu_ref.svh
`ifndef VALU_REF_SVH
`define VALU_REF_SVH

data_t ref_acc;   // model accumulator, lane width, zero extended

function automatic data_t lane_ones(sew_t s);
    return ~64'd0 >> (64 - (8 << s));
endfunction

function automatic data_t lane_get(data_t v, sew_t s, int i);
    return (v >> (i * (8 << s))) & lane_ones(s);
endfunction

function automatic data_t lane_sext(data_t v, sew_t s);
    return v[(8 << s) - 1] ? (v | ~lane_ones(s)) : v;
endfunction

// identity of each reduction code at the given width
function automatic data_t red_identity(logic [2:0] code, sew_t s);
    data_t m;
    m = lane_ones(s);
    case (code)
        3'd1, 3'd4: return m;
        3'd5:       return m >> 1;         // largest signed
        3'd7:       return m ^ (m >> 1);   // most negative
        default:    return '0;
    endcase
endfunction

// x and y are zero extended lane values
function automatic data_t lane_fold(logic [2:0] code, data_t x, data_t y, sew_t s);
    logic lt_u;
    logic lt_s;
    lt_u = x < y;
    lt_s = $signed(lane_sext(x, s)) < $signed(lane_sext(y, s));
    case (code)
        3'd0:    return (x + y) & lane_ones(s);
        3'd1:    return x & y;
        3'd2:    return x | y;
        3'd3:    return x ^ y;
        3'd4:    return lt_u ? x : y;
        3'd5:    return lt_s ? x : y;
        3'd6:    return lt_u ? y : x;
        default: return lt_s ? y : x;
    endcase
endfunction

// returns 1 when the beat should produce a response
function automatic logic valu_ref_calc(input mnr_t mnr, input func_t func, input logic mask,
        input sew_t sew, input data_t d0, input data_t d1, input be_t be,
        input logic st, input logic en, output data_t res);
    int    ew;
    data_t a;
    data_t b;
    data_t r;
    data_t e;
    ew  = 8 << sew;
    res = '0;
    if (mnr == mnr_mvv) begin
        if (func[5:3] != 3'b000)
            return 1'b0;
        if (st)
            ref_acc = lane_get(d0, sew, 0);
        for (int i = 0; i < 64 / ew; i++) begin
            e = be[i * ew / 8] ? lane_get(d1, sew, i) : red_identity(func[2:0], sew);
            ref_acc = lane_fold(func[2:0], ref_acc, e, sew);
        end
        res = ref_acc;
        return en;
    end
    case (func)
        6'b001001: res = d0 & d1;
        6'b001010: res = d0 | d1;
        6'b001011: res = d0 ^ d1;
        6'b010111: res = d0;
        6'b000000, 6'b000010, 6'b000011, 6'b000100, 6'b000101, 6'b000110, 6'b000111: begin
            for (int i = 0; i < 64 / ew; i++) begin
                a = lane_get(d0, sew, i);
                b = lane_get(d1, sew, i);
                case (func[2:0])
                    3'd2:    r = b - a;
                    3'd3:    r = a - b;
                    default: r = lane_fold(func[2:0], b, a, sew);
                endcase
                res = res | ((r & lane_ones(sew)) << (i * ew));
            end
        end
        default: return 1'b0;
    endcase
    return (func != 6'b010111) || mask;
endfunction

`endif

// File: tests/valu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module valu_tb import valu_cfg_pkg::*, valu_op_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int n_settle     = 8;
    localparam int n_arith      = 200;
    localparam int n_logic      = 120;
    localparam int n_red        = 60;    // up to 4 beats each
    localparam int n_side       = 100;
    localparam int n_unsup      = 120;
    localparam int n_tests      = 6;
    localparam int timeout_cycles = reset_cycles + n_settle + n_arith + n_logic + 4 * n_red
                                  + n_side + n_unsup + n_tests * (2 * pipe_lat + 2) + 50;

    logic  clk;
    logic  rst;
    logic  req_valid;
    mnr_t  req_op_mnr;
    func_t req_func_id;
    sew_t  req_sew;
    data_t req_data0;
    data_t req_data1;
    be_t   req_be;
    addr_t req_addr;
    vl_t   req_vl;
    logic  req_start;
    logic  req_end;
    logic  req_mask;
    off_t  req_off;
    logic  resp_valid;
    data_t resp_data;
    sew_t  resp_sew;
    logic  resp_start;
    logic  resp_end;
    logic  resp_sca;
    addr_t resp_addr;
    vl_t   resp_vl;
    be_t   resp_be;
    off_t  resp_off;

    int          cycle  = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests  = 0;
    logic [31:0] rng_state = 32'h7e8f49a4;

    // expected responses, oldest first
    int    exp_due [$];
    data_t exp_data [$];
    logic  exp_sca [$];

    // inputs of the last four cycles, indexed by cycle mod 4
    logic  hist_rst [4];
    addr_t hist_addr [4];
    vl_t   hist_vl [4];
    off_t  hist_off [4];
    be_t   hist_be [4];
    sew_t  hist_sew [4];
    logic  hist_start [4];
    logic  hist_end [4];

    func_t elem_codes [11] = '{func_add, func_sub, func_rsub, func_minu, func_min, func_maxu,
                               func_max, func_and, func_or, func_xor, func_move};

    `include "valu_ref.svh"

    valu_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic data_t rand64();
        data_t v;
        v[63:32] = next_rand();
        v[31:0]  = next_rand();
        return v;
    endfunction

    function automatic int pick(int n);
        return int'(next_rand() % n);
    endfunction

    function automatic mnr_t other_mnr();
        mnr_t m;
        m = mnr_t'(next_rand());
        return (m == mnr_mvv) ? 3'd0 : m;
    endfunction

    function automatic logic is_elem_code(func_t f);
        foreach (elem_codes[i]) begin
            if (elem_codes[i] == f)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic report_error(input string what, input string got, input string exp);
        errors++;
        $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got, exp);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_data(input string what, input data_t got, input data_t exp);
        checks++;
        if (got !== exp)
            report_error(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp)
            report_error(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_be(input string what, input be_t got, input be_t exp);
        checks++;
        if (got !== exp)
            report_error(what, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_vl(input string what, input vl_t got, input vl_t exp);
        checks++;
        if (got !== exp)
            report_error(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_off(input string what, input off_t got, input off_t exp);
        checks++;
        if (got !== exp)
            report_error(what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_sew(input string what, input sew_t got, input sew_t exp);
        checks++;
        if (got !== exp)
            report_error(what, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp)
            report_error(what, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    // compare process, outputs are settled at the falling edge
    always @(negedge clk) begin
        int   k;
        logic clr;
        k   = (cycle + 1) % 4;    // three cycles back
        clr = hist_rst[k] | hist_rst[(cycle + 2) % 4] | hist_rst[(cycle + 3) % 4];
        if (cycle >= 1) begin
            check_addr("resp_addr", resp_addr, clr ? addr_t'(0) : hist_addr[k]);
            check_vl("resp_vl", resp_vl, clr ? vl_t'(0) : hist_vl[k]);
            check_off("resp_off", resp_off, clr ? off_t'(0) : hist_off[k]);
            check_be("resp_be", resp_be, clr ? be_t'(0) : hist_be[k]);
            check_sew("resp_sew", resp_sew, clr ? sew_t'(0) : hist_sew[k]);
            check_flag("resp_start", resp_start, clr ? 1'b0 : hist_start[k]);
            check_flag("resp_end", resp_end, clr ? 1'b0 : hist_end[k]);
            while (exp_due.size() > 0 && exp_due[0] < cycle) begin
                report_failure($sformatf("missing response, due in cycle %0d", exp_due[0]));
                exp_due.delete(0);
                exp_data.delete(0);
                exp_sca.delete(0);
            end
            if (resp_valid) begin
                if (exp_due.size() == 0 || exp_due[0] != cycle) begin
                    report_failure($sformatf("unexpected response in cycle %0d", cycle));
                end else begin
                    check_data("resp_data", resp_data, exp_data[0]);
                    check_flag("resp_sca", resp_sca, exp_sca[0]);
                    exp_due.delete(0);
                    exp_data.delete(0);
                    exp_sca.delete(0);
                end
            end else begin
                check_data("idle resp_data", resp_data, '0);
                check_flag("idle resp_sca", resp_sca, 1'b0);
            end
        end
        hist_rst[cycle % 4]   = rst;
        hist_addr[cycle % 4]  = req_addr;
        hist_vl[cycle % 4]    = req_vl;
        hist_off[cycle % 4]   = req_off;
        hist_be[cycle % 4]    = req_be;
        hist_sew[cycle % 4]   = req_sew;
        hist_start[cycle % 4] = req_start & req_valid;
        hist_end[cycle % 4]   = req_end & req_valid;
    end

    task automatic drive_beat(input logic valid, input mnr_t mnr, input func_t func,
            input logic mask, input sew_t sew, input data_t d0, input data_t d1,
            input be_t be, input logic st, input logic en);
        data_t exp;
        logic  hit;
        @(posedge clk);
        req_valid   <= valid;
        req_op_mnr  <= mnr;
        req_func_id <= func;
        req_mask    <= mask;
        req_sew     <= sew;
        req_data0   <= d0;
        req_data1   <= d1;
        req_be      <= be;
        req_start   <= st;
        req_end     <= en;
        req_addr    <= next_rand();
        req_vl      <= vl_t'(next_rand());
        req_off     <= off_t'(next_rand());
        if (valid) begin
            hit = valu_ref_calc(mnr, func, mask, sew, d0, d1, be, st, en, exp);
            if (hit) begin
                exp_due.push_back(cycle + 1 + pipe_lat);
                exp_data.push_back(exp);
                exp_sca.push_back(mnr == mnr_mvv);
            end
        end
    endtask

    task automatic drive_idle();
        logic [31:0] r;
        r = next_rand();
        drive_beat(1'b0, other_mnr(), func_t'(r[5:0]), r[6], sew_t'(r[8:7]), rand64(),
                   rand64(), be_t'(r[23:16]), r[9], r[10]);
    endtask

    task automatic drive_elem(input logic valid, input int first, input int count);
        data_t       d0;
        data_t       d1;
        logic [31:0] r;
        d0 = rand64();
        d1 = rand64();
        r  = next_rand();
        if (r[7:5] == 3'd0)
            d1 = d0;   // equal operands for min and max
        drive_beat(valid, other_mnr(), elem_codes[first + pick(count)], r[0], sew_t'(r[2:1]),
                   d0, d1, be_t'(r[15:8]), r[3], r[4]);
    endtask

    task automatic drive_unsupported();
        mnr_t        mnr;
        func_t       func;
        logic [31:0] r;
        r = next_rand();
        if (r[0]) begin
            mnr  = mnr_mvv;
            func = func_t'(r[13:8]) | 6'b001000;
        end else begin
            mnr  = other_mnr();
            func = func_t'(r[13:8]);
            while (is_elem_code(func))
                func = func_t'(next_rand());
        end
        drive_beat(1'b1, mnr, func, r[1], sew_t'(r[3:2]), rand64(), rand64(),
                   be_t'(r[23:16]), r[4], r[5]);
    endtask

    task automatic finish_test(input string name, input int start_err);
        while (exp_due.size() > 0)
            drive_idle();
        repeat (pipe_lat + 1)
            drive_idle();   // room for stray responses
        tests++;
        $display("test %s: %0d errors", name, errors - start_err);
    endtask

    task automatic run_reset_test();
        int start_err;
        start_err = errors;
        for (int i = 0; i < reset_cycles + n_settle; i++) begin
            @(posedge clk);
            if (i == reset_cycles - 1)
                rst <= 1'b0;
            @(negedge clk);
            check_flag("reset resp_valid", resp_valid, 1'b0);
            check_flag("reset resp_sca", resp_sca, 1'b0);
            check_flag("reset resp_start", resp_start, 1'b0);
            check_flag("reset resp_end", resp_end, 1'b0);
            check_data("reset resp_data", resp_data, '0);
        end
        finish_test("reset", start_err);
    endtask

    task automatic run_red_test();
        int          start_err;
        int          n;
        logic [31:0] r;
        be_t         be;
        start_err = errors;
        for (int k = 0; k < n_red; k++) begin
            r = next_rand();
            n = 1 + r[1:0];
            for (int b = 0; b < n; b++) begin
                be = (r[9:8] == 2'd0) ? '0 : be_t'(next_rand());   // all masked now and then
                drive_beat(1'b1, mnr_mvv, {3'b000, r[4:2]}, r[7], sew_t'(r[6:5]), rand64(),
                           rand64(), be, b == 0, b == n - 1);
            end
        end
        finish_test("reduction", start_err);
    endtask

    initial begin
        int start_err;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op_mnr  = '0;
        req_func_id = '0;
        req_sew     = '0;
        req_data0   = '0;
        req_data1   = '0;
        req_be      = '0;
        req_addr    = '0;
        req_vl      = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        req_mask    = 1'b0;
        req_off     = '0;
        for (int i = 0; i < 4; i++) begin
            hist_rst[i] = 1'b1;
        end

        run_reset_test();

        start_err = errors;
        repeat (n_arith)
            drive_elem(1'b1, 0, 7);
        finish_test("arith", start_err);

        start_err = errors;
        repeat (n_logic)
            drive_elem(1'b1, 7, 4);
        finish_test("logic", start_err);

        run_red_test();

        start_err = errors;
        repeat (n_side)
            drive_elem(next_rand() % 2 == 1, 0, 11);   // valid toggles at random
        finish_test("sideband", start_err);

        start_err = errors;
        repeat (n_unsup) begin
            if (pick(2) == 1)
                drive_elem(1'b1, 0, 11);
            else
                drive_unsupported();
        end
        finish_test("unsupported", start_err);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: valu.f
+incdir+tests
hw/valu_cfg_pkg.sv
hw/valu_op_pkg.sv
hw/sideband_delay.sv
hw/valu_decode.sv
hw/valu_arith.sv
hw/valu_logic.sv
hw/valu_reduce.sv
hw/valu_resp.sv
hw/valu_top.sv
tests/valu_tb.sv
